//--- Makefile
# Verilator build and run for the APB UART receiver

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ns
TOP       ?= tb_apb_uart_rx
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/uart_rx_pkg.sv
// UART receiver shared definitions: APB register map, field widths and reset values
`default_nettype none

package uart_rx_pkg;

  // ****************************************
  // APB bus geometry
  // ****************************************
  localparam int addr_width = 3;
  // Also the widest frame
  localparam int data_width = 8;

  // Register map
  localparam logic [addr_width-1:0] addr_data_sr  = 3'd0;
  localparam logic [addr_width-1:0] addr_error_sr = 3'd1;
  localparam logic [addr_width-1:0] addr_bit_cr0  = 3'd2;
  localparam logic [addr_width-1:0] addr_bit_cr1  = 3'd3;
  localparam logic [addr_width-1:0] addr_data_cr  = 3'd4;
  localparam logic [addr_width-1:0] addr_rx_data  = 3'd6;

  // ****************************************
  // Frame configuration
  // ****************************************
  localparam int data_size_width = 4;
  localparam int min_data_size   = 5;
  localparam int max_data_size   = 8;

  // Working setup right out of reset
  localparam int reset_bit_period = 10;
  localparam int reset_data_size  = 8;

  // Error status bit positions
  localparam int err_framing_bit = 0;
  localparam int err_overrun_bit = 1;

  // ****************************************
  // Write data word, decoded by address
  // ****************************************
  typedef union packed {
    // Bit period high byte
    struct packed {
      logic [1:0] rsvd;
      logic [5:0] period_hi;
    } bit_cr1;
    // Data size control word
    struct packed {
      logic [3:0]                 rsvd;
      logic [data_size_width-1:0] data_size;
    } data_cr;
  } apb_wdata_u;

endpackage

`default_nettype wire

//--- compile.f
common/uart_rx_pkg.sv
uart_rx/bit_timer.sv
uart_rx/rx_shifter.sv
uart_rx/rx_sequencer.sv
hdl/apb_rx_regs.sv
hdl/apb_uart_rx.sv
sim/tb_apb_uart_rx.sv

//--- hdl/apb_rx_regs.sv
// APB receiver register file holding bit period and data size config, status and error flags
`timescale 1ns/1ns
`default_nettype none

module apb_rx_regs #(
  parameter int period_width = 14
) (
  input  wire                                   tb_clk,
  input  wire                                   arst_n,
  input  wire                                   psel,
  input  wire                                   penable,
  input  wire                                   pwrite,
  input  wire [uart_rx_pkg::addr_width-1:0]     paddr,
  input  wire [uart_rx_pkg::data_width-1:0]     pwdata,
  input  wire                                   frame_valid,
  input  wire                                   frame_bad,
  input  wire [uart_rx_pkg::data_width-1:0]     rx_word,
  output logic [uart_rx_pkg::data_width-1:0]    prdata,
  output logic                                  pslverr,
  output logic [period_width-1:0]               bit_period,
  output logic [uart_rx_pkg::data_size_width-1:0] data_size
);

  import uart_rx_pkg::*;

  apb_wdata_u            wdata;
  logic                  wr_access;
  logic                  rd_access;
  logic                  wr_err;
  logic                  rd_err;
  logic                  wr_en;
  logic [data_width-1:0] rd_mux;
  logic [data_width-1:0] rx_data;
  logic                  data_ready;
  logic                  framing_err;
  logic                  overrun_err;
  logic                  clear_ready;
  logic                  clear_errors;

  assign wdata = pwdata;

  // Access phase with zero wait states
  assign wr_access = psel & penable & pwrite;
  assign rd_access = psel & penable & ~pwrite;

  // ****************************************
  // Access decode
  // ****************************************
  always_comb
  begin
    wr_err = 1'b0;
    case (paddr)
      addr_bit_cr0, addr_bit_cr1:
        wr_err = 1'b0;
      // Range check on the size field
      addr_data_cr:
        wr_err = (wdata.data_cr.data_size < data_size_width'(min_data_size)) ||
                 (wdata.data_cr.data_size > data_size_width'(max_data_size));
      // Status, rx data and holes are read only
      default:
        wr_err = 1'b1;
    endcase
  end

  always_comb
  begin
    rd_err = 1'b0;
    rd_mux = '0;
    case (paddr)
      addr_data_sr:
        rd_mux = data_width'(data_ready);
      addr_error_sr:
      begin
        rd_mux[err_framing_bit] = framing_err;
        rd_mux[err_overrun_bit] = overrun_err;
      end
      addr_bit_cr0:
        rd_mux = bit_period[data_width-1:0];
      // Upper period bits with the top of the byte read as 0
      addr_bit_cr1:
        rd_mux = data_width'(bit_period >> data_width);
      addr_data_cr:
        rd_mux = data_width'(data_size);
      addr_rx_data:
        rd_mux = rx_data;
      default:
        rd_err = 1'b1;
    endcase
  end

  assign prdata  = rd_access ? rd_mux : '0;
  assign pslverr = (wr_access & wr_err) | (rd_access & rd_err);
  assign wr_en   = wr_access & ~wr_err;

  // ****************************************
  // Configuration registers
  // ****************************************
  always_ff @(posedge tb_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      bit_period <= period_width'(reset_bit_period);
      data_size  <= data_size_width'(reset_data_size);
    end
    else if (wr_en)
    begin
      case (paddr)
        addr_bit_cr0:
          bit_period[data_width-1:0] <= pwdata;
        addr_bit_cr1:
          bit_period[period_width-1:data_width] <=
            wdata.bit_cr1.period_hi[period_width-data_width-1:0];
        addr_data_cr:
          data_size <= wdata.data_cr.data_size;
        default:
          ;
      endcase
    end
  end

  // ****************************************
  // Status flags and rx data
  // ****************************************
  // Read to clear
  assign clear_ready  = rd_access & (paddr == addr_rx_data);
  assign clear_errors = rd_access & (paddr == addr_error_sr);

  always_ff @(posedge tb_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      data_ready  <= 1'b0;
      framing_err <= 1'b0;
      overrun_err <= 1'b0;
    end
    else
    begin
      // New frame wins over a clearing read
      if (frame_valid)
        data_ready <= 1'b1;
      else if (clear_ready)
        data_ready <= 1'b0;
      if (frame_bad)
        framing_err <= 1'b1;
      else if (clear_errors)
        framing_err <= 1'b0;
      // Unread word about to be replaced
      if (frame_valid && data_ready && !clear_ready)
        overrun_err <= 1'b1;
      else if (clear_errors)
        overrun_err <= 1'b0;
    end
  end

  always_ff @(posedge tb_clk or negedge arst_n)
  begin
    if (!arst_n)
      rx_data <= '0;
    else if (frame_valid)
      rx_data <= rx_word;
  end

endmodule

`default_nettype wire

//--- hdl/apb_uart_rx.sv
// APB UART receiver top: register file joined to the synchronizer, sequencer and bit timer
`timescale 1ns/1ns
`default_nettype none

module apb_uart_rx #(
  parameter int period_width = 14,
  parameter int sync_stages  = 2
) (
  input  wire                                tb_clk,
  input  wire                                arst_n,
  input  wire                                serial_in,
  input  wire                                psel,
  input  wire                                penable,
  input  wire                                pwrite,
  input  wire [uart_rx_pkg::addr_width-1:0]  paddr,
  input  wire [uart_rx_pkg::data_width-1:0]  pwdata,
  output logic [uart_rx_pkg::data_width-1:0] prdata,
  output logic                               pslverr
);

  import uart_rx_pkg::*;

  // Config from the register file
  logic [period_width-1:0]    bit_period;
  logic [data_size_width-1:0] data_size;

  // Receive path
  logic                  line;
  logic                  start_edge;
  logic                  bit_tick;
  logic                  timer_start;
  logic                  half_period;
  logic                  shift_en;
  logic                  frame_valid;
  logic                  frame_bad;
  logic [data_width-1:0] rx_word;

  // ****************************************
  // APB side
  // ****************************************
  apb_rx_regs #(
    .period_width (period_width)
  ) regs0 (
    .tb_clk      (tb_clk),
    .arst_n      (arst_n),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .frame_valid (frame_valid),
    .frame_bad   (frame_bad),
    .rx_word     (rx_word),
    .prdata      (prdata),
    .pslverr     (pslverr),
    .bit_period  (bit_period),
    .data_size   (data_size)
  );

  // ****************************************
  // Serial side
  // ****************************************
  rx_shifter #(
    .sync_stages (sync_stages)
  ) shifter0 (
    .tb_clk     (tb_clk),
    .arst_n     (arst_n),
    .serial_in  (serial_in),
    .shift_en   (shift_en),
    .data_size  (data_size),
    .line       (line),
    .start_edge (start_edge),
    .rx_word    (rx_word)
  );

  rx_sequencer seq0 (
    .tb_clk      (tb_clk),
    .arst_n      (arst_n),
    .start_edge  (start_edge),
    .line        (line),
    .bit_tick    (bit_tick),
    .data_size   (data_size),
    .timer_start (timer_start),
    .half_period (half_period),
    .shift_en    (shift_en),
    .frame_valid (frame_valid),
    .frame_bad   (frame_bad)
  );

  bit_timer #(
    .period_width (period_width)
  ) timer0 (
    .tb_clk      (tb_clk),
    .arst_n      (arst_n),
    .timer_start (timer_start),
    .half_period (half_period),
    .bit_period  (bit_period),
    .bit_tick    (bit_tick)
  );

endmodule

`default_nettype wire

//--- sim/tb_apb_uart_rx.sv
// APB UART receiver testbench with directed APB and serial frame tests and register checks
`timescale 1ns/1ns
`default_nettype none

module tb_apb_uart_rx;

  import uart_rx_pkg::*;

  // Serial bit period in clock cycles for all frames
  localparam int rx_period = 10;
  // Poll limit for status waits
  localparam int max_polls = 400;

  logic                  tb_clk;
  logic                  arst_n;
  logic                  serial_in;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [addr_width-1:0] paddr;
  logic [data_width-1:0] pwdata;
  logic [data_width-1:0] prdata;
  logic                  pslverr;

  int mismatch_count;
  int other_count;

  apb_uart_rx #(
    .period_width (14),
    .sync_stages  (2)
  ) dut0 (
    .tb_clk    (tb_clk),
    .arst_n    (arst_n),
    .serial_in (serial_in),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pslverr   (pslverr)
  );

  // 8 ns clock
  always #4 tb_clk = ~tb_clk;

  // ****************************************
  // Checking and bus tasks
  // ****************************************
  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    assert (got === exp)
    else
    begin
      mismatch_count++;
      $display("mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // One zero-wait APB transfer with setup then access phase
  task automatic apb_access(input logic write, input logic [2:0] addr, input logic [7:0] wdata,
                            output logic [7:0] rdata, output logic err);
    @(negedge tb_clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge tb_clk);
    penable = 1'b1;
    // Combinational response settles before the rising edge
    #1;
    rdata = prdata;
    err   = pslverr;
    @(negedge tb_clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [2:0] addr, input logic [7:0] data, input logic exp_err);
    logic [7:0] rdata;
    logic       err;
    apb_access(1'b1, addr, data, rdata, err);
    check_byte($sformatf("pslverr write[%h]", addr), {7'b0, err}, {7'b0, exp_err});
  endtask

  task automatic apb_read(input logic [2:0] addr, input logic [7:0] exp_data, input logic exp_err);
    logic [7:0] rdata;
    logic       err;
    apb_access(1'b0, addr, 8'h00, rdata, err);
    check_byte($sformatf("prdata[%h]", addr), rdata, exp_data);
    check_byte($sformatf("pslverr read[%h]", addr), {7'b0, err}, {7'b0, exp_err});
  endtask

  // Poll a status register until any bit is set
  task automatic wait_flag(input logic [2:0] addr, output logic [7:0] rdata);
    logic err;
    logic found;
    int   polls;
    found = 1'b0;
    rdata = 8'h00;
    for (polls = 0; polls < max_polls && !found; polls++)
    begin
      apb_access(1'b0, addr, 8'h00, rdata, err);
      found = (rdata != 8'h00);
    end
    assert (found)
    else
    begin
      other_count++;
      $display("timeout: register %h stayed zero after %0d polls", addr, max_polls);
    end
  endtask

  // Start bit, data LSB first, stop bit, then one idle bit
  task automatic send_frame(input logic [7:0] data, input int nbits, input logic stop_bit,
                            input int period);
    @(negedge tb_clk);
    serial_in = 1'b0;
    repeat (period) @(negedge tb_clk);
    for (int i = 0; i < nbits; i++)
    begin
      serial_in = data[i];
      repeat (period) @(negedge tb_clk);
    end
    serial_in = stop_bit;
    repeat (period) @(negedge tb_clk);
    serial_in = 1'b1;
    repeat (period) @(negedge tb_clk);
  endtask

  // Random frame of nbits with the expected word right-aligned and zero filled
  task automatic receive_random(input int nbits);
    logic [7:0] data;
    logic [7:0] mask;
    logic [7:0] status;
    data = 8'($urandom());
    mask = 8'((1 << nbits) - 1);
    send_frame(data, nbits, 1'b1, rx_period);
    wait_flag(addr_data_sr, status);
    check_byte("data_sr", status, 8'h01);
    apb_read(addr_rx_data, data & mask, 1'b0);
    // Cleared by the rx data read
    apb_read(addr_data_sr, 8'h00, 1'b0);
  endtask

  // ****************************************
  // Directed tests
  // ****************************************
  task automatic test_reset_values();
    apb_read(addr_bit_cr0, 8'h0a, 1'b0);
    apb_read(addr_bit_cr1, 8'h00, 1'b0);
    apb_read(addr_data_cr, 8'h08, 1'b0);
    apb_read(addr_data_sr, 8'h00, 1'b0);
    apb_read(addr_error_sr, 8'h00, 1'b0);
  endtask

  task automatic test_config_errors();
    // Period 1000 is 0x03e8
    apb_write(addr_bit_cr0, 8'he8, 1'b0);
    apb_write(addr_bit_cr1, 8'h03, 1'b0);
    apb_write(addr_data_cr, 8'h05, 1'b0);
    apb_read(addr_bit_cr0, 8'he8, 1'b0);
    apb_read(addr_bit_cr1, 8'h03, 1'b0);
    apb_read(addr_data_cr, 8'h05, 1'b0);
    // Rejected accesses
    apb_write(addr_data_cr, 8'h09, 1'b1);
    apb_write(addr_data_cr, 8'h04, 1'b1);
    apb_write(addr_rx_data, 8'h5a, 1'b1);
    apb_write(3'd7, 8'h11, 1'b1);
    apb_read(3'd7, 8'h00, 1'b1);
    apb_read(addr_bit_cr0, 8'he8, 1'b0);
    apb_read(addr_bit_cr1, 8'h03, 1'b0);
    apb_read(addr_data_cr, 8'h05, 1'b0);
    // Back to the working setup
    apb_write(addr_bit_cr0, 8'h0a, 1'b0);
    apb_write(addr_bit_cr1, 8'h00, 1'b0);
    apb_write(addr_data_cr, 8'h08, 1'b0);
  endtask

  task automatic test_short_sizes();
    apb_write(addr_data_cr, 8'h05, 1'b0);
    receive_random(5);
    apb_write(addr_data_cr, 8'h07, 1'b0);
    receive_random(7);
    apb_write(addr_data_cr, 8'h08, 1'b0);
  endtask

  task automatic test_framing_error();
    logic [7:0] status;
    send_frame(8'($urandom()), 8, 1'b0, rx_period);
    wait_flag(addr_error_sr, status);
    check_byte("error_sr", status, 8'h01);
    apb_read(addr_data_sr, 8'h00, 1'b0);
    // Read to clear
    apb_read(addr_error_sr, 8'h00, 1'b0);
  endtask

  task automatic test_overrun();
    logic [7:0] first;
    logic [7:0] second;
    logic [7:0] status;
    first  = 8'($urandom());
    second = 8'($urandom());
    // Second word differs so the replacement shows
    if (second == first)
      second = ~first;
    send_frame(first, 8, 1'b1, rx_period);
    wait_flag(addr_data_sr, status);
    send_frame(second, 8, 1'b1, rx_period);
    wait_flag(addr_error_sr, status);
    check_byte("error_sr", status, 8'h02);
    apb_read(addr_data_sr, 8'h01, 1'b0);
    apb_read(addr_rx_data, second, 1'b0);
  endtask

  // ****************************************
  // Main sequence
  // ****************************************
  initial
  begin
    tb_clk         = 1'b0;
    arst_n         = 1'b0;
    serial_in      = 1'b1;
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    paddr          = '0;
    pwdata         = '0;
    mismatch_count = 0;
    other_count    = 0;
    void'($urandom(32'h9d54_fe10));
    repeat (8) @(negedge tb_clk);
    arst_n = 1'b1;
    test_reset_values();
    test_config_errors();
    receive_random(8);
    test_short_sizes();
    test_framing_error();
    test_overrun();
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- uart_rx/bit_timer.sv
// UART bit timer: clock cycle down-counter producing half-bit and full-bit ticks
`timescale 1ns/1ns
`default_nettype none

module bit_timer #(
  parameter int period_width = 14
) (
  input  wire                    tb_clk,
  input  wire                    arst_n,
  input  wire                    timer_start,
  input  wire                    half_period,
  input  wire [period_width-1:0] bit_period,
  output logic                   bit_tick
);

  logic [period_width-1:0] count;
  logic [period_width-1:0] load_value;
  logic                    running;

  // Half period for the start bit mid-point
  assign load_value = half_period ? (bit_period >> 1) : bit_period;

  always_ff @(posedge tb_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      count   <= '0;
      running <= 1'b0;
    end
    else if (timer_start)
    begin
      count   <= load_value - 1'b1;
      running <= 1'b1;
    end
    // Free-running reload, picks up a new period here
    else if (bit_tick)
      count <= bit_period - 1'b1;
    else if (running)
      count <= count - 1'b1;
  end

  // Tick on the terminal count
  assign bit_tick = running & (count == '0);

endmodule

`default_nettype wire

//--- uart_rx/rx_sequencer.sv
// UART receive sequencer: frame FSM steering the bit timer and the data shifter
`timescale 1ns/1ns
`default_nettype none

module rx_sequencer (
  input  wire                                   tb_clk,
  input  wire                                   arst_n,
  input  wire                                   start_edge,
  input  wire                                   line,
  input  wire                                   bit_tick,
  input  wire [uart_rx_pkg::data_size_width-1:0] data_size,
  output logic                                  timer_start,
  output logic                                  half_period,
  output logic                                  shift_en,
  output logic                                  frame_valid,
  output logic                                  frame_bad
);

  import uart_rx_pkg::*;

  // State encoding
  localparam logic [1:0] idle        = 2'd0;
  localparam logic [1:0] start_check = 2'd1;
  localparam logic [1:0] data        = 2'd2;
  localparam logic [1:0] stop        = 2'd3;

  logic [1:0]                 state;
  logic [1:0]                 next_state;
  logic [data_size_width-1:0] bit_cnt;
  logic                       last_bit;

  // Final data bit of the configured size
  assign last_bit = (bit_cnt == data_size - 1'b1);

  // ****************************************
  // Next state
  // ****************************************
  always_comb
  begin
    next_state = state;
    case (state)
      idle:
        if (start_edge)
          next_state = start_check;
      // Start bit high again at mid-bit means a glitch
      start_check:
        if (bit_tick)
          next_state = line ? idle : data;
      data:
        if (bit_tick && last_bit)
          next_state = stop;
      stop:
        if (bit_tick)
          next_state = idle;
      default:
        next_state = idle;
    endcase
  end

  always_ff @(posedge tb_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state   <= idle;
      bit_cnt <= '0;
    end
    else
    begin
      state <= next_state;
      // Count restarts for every frame
      if (state == start_check)
        bit_cnt <= '0;
      else if (shift_en)
        bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // ****************************************
  // Control outputs
  // ****************************************
  // Half load on the start edge, full load once the start bit is confirmed
  assign timer_start = ((state == idle) & start_edge) |
                       ((state == start_check) & bit_tick & ~line);
  assign half_period = (state == idle);

  // One shift per data bit tick
  assign shift_en = (state == data) & bit_tick;

  // Stop bit decides the frame outcome
  assign frame_valid = (state == stop) & bit_tick & line;
  assign frame_bad   = (state == stop) & bit_tick & ~line;

endmodule

`default_nettype wire

//--- uart_rx/rx_shifter.sv
// UART receive shifter with input synchronizer, start edge detect and aligned shift register
`timescale 1ns/1ns
`default_nettype none

module rx_shifter #(
  parameter int sync_stages = 2
) (
  input  wire                                   tb_clk,
  input  wire                                   arst_n,
  input  wire                                   serial_in,
  input  wire                                   shift_en,
  input  wire [uart_rx_pkg::data_size_width-1:0] data_size,
  output logic                                  line,
  output logic                                  start_edge,
  output logic [uart_rx_pkg::data_width-1:0]    rx_word
);

  import uart_rx_pkg::*;

  logic [sync_stages-1:0]     sync_q;
  logic                       line_q;
  logic [data_width-1:0]      shift_q;
  logic [data_size_width-1:0] align;

  // ****************************************
  // Synchronizer and edge detect
  // ****************************************
  always_ff @(posedge tb_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      // Line idles high
      sync_q <= '1;
      line_q <= 1'b1;
    end
    else
    begin
      sync_q[0] <= serial_in;
      for (int i = 1; i < sync_stages; i++)
        sync_q[i] <= sync_q[i-1];
      line_q <= line;
    end
  end

  assign line = sync_q[sync_stages-1];

  // High to low on the synchronized line
  assign start_edge = line_q & ~line;

  // ****************************************
  // Data shift register
  // ****************************************
  // LSB first so new bits enter at the top
  always_ff @(posedge tb_clk or negedge arst_n)
  begin
    if (!arst_n)
      shift_q <= '0;
    else if (shift_en)
      shift_q <= {line, shift_q[data_width-1:1]};
  end

  // Short frames sit high and move down to bit 0
  assign align   = data_size_width'(data_width) - data_size;
  assign rx_word = shift_q >> align;

endmodule

`default_nettype wire
